/* flist.f */
hw/lc4_pkg.sv
hw/lc4_stage_if.sv
hw/lc4_decoder.sv
hw/lc4_regfile.sv
hw/lc4_alu.sv
hw/lc4_fetch_decode.sv
hw/lc4_exec_mem.sv
hw/lc4_writeback.sv
hw/lc4_core.sv
verif/lc4_tb.sv

/* Bender.yml */
package:
  name: lc4_pipeline

sources:
  - hw/lc4_pkg.sv
  - hw/lc4_stage_if.sv
  - hw/lc4_decoder.sv
  - hw/lc4_regfile.sv
  - hw/lc4_alu.sv
  - hw/lc4_fetch_decode.sv
  - hw/lc4_exec_mem.sv
  - hw/lc4_writeback.sv
  - hw/lc4_core.sv
  - target: simulation
    files:
      - verif/lc4_tb.sv

/* verif/lc4_tb.sv */
/*
 * LC4 pipeline testbench
 * clock and reset, instruction and data memory models, random program builder,
 * ISA model with expected fetch and store lists, concurrent checks
 */
`timescale 1ns/100ps

module lc4_tb;

   localparam int W                       = lc4_pkg::WORD_W;
   localparam logic [W-1:0] P_RESET_PC    = lc4_pkg::RESET_PC;
   localparam int MAX_FETCH               = 2048; // model steps reaching far past the program end
   localparam int MAX_ST                  = 256;
   localparam int N_GROUPS                = 40;   // random instruction groups
   localparam int TIMEOUT                 = 1500; // cycle limit kept below MAX_FETCH

   logic         gwe;
   logic         i_rst_n;
   logic [W-1:0] i_cur_insn;
   logic [W-1:0] i_dmem_data;
   logic [W-1:0] o_cur_pc;
   logic [W-1:0] o_dmem_addr;
   logic         o_dmem_we;
   logic [W-1:0] o_dmem_towrite;

   logic [W-1:0] imem [2**W];
   logic [W-1:0] dmem [2**W];
   logic [W-1:0] ref_mem [2**W];         // model copy of the data memory

   logic [W-1:0] fetch_exp [MAX_FETCH];  // pc per fetch cycle
   logic         fetch_mem [MAX_FETCH];  // that fetch is a load or store
   logic [W-1:0] st_addr_exp [MAX_ST];
   logic [W-1:0] st_data_exp [MAX_ST];
   int           n_st_exp;
   int           build_ptr;

   int           cyc = 0;                // cycles since reset release
   int           st_seen = 0;
   logic [W-1:0] exp_pc;
   logic [W-1:0] exp_st_addr;
   logic [W-1:0] exp_st_data;
   logic         exp_mem_op = 1'b0;      // memory stage holds a load or store

   lc4_core #(
      .P_RESET_PC (P_RESET_PC)
   ) DUT (
      .gwe            (gwe),
      .i_rst_n        (i_rst_n),
      .i_cur_insn     (i_cur_insn),
      .i_dmem_data    (i_dmem_data),
      .o_cur_pc       (o_cur_pc),
      .o_dmem_addr    (o_dmem_addr),
      .o_dmem_we      (o_dmem_we),
      .o_dmem_towrite (o_dmem_towrite)
   );

   // combinational memory reads with the dmem written at the edge
   assign i_cur_insn  = imem[o_cur_pc];
   assign i_dmem_data = dmem[o_dmem_addr];

   always @(posedge gwe) begin
      if (o_dmem_we)
         dmem[o_dmem_addr] <= o_dmem_towrite;
   end

   initial begin
      gwe = 1'b0;
      forever #2 gwe = ~gwe; // 4 ns period
   end

   task automatic report_failure(input string line);
      $display("%s", line);
      $display("Test failed");
   endtask

   task automatic report_mismatch(input string sig, input logic [W-1:0] exp,
                                  input logic [W-1:0] got);
      report_failure($sformatf("mismatch at %0d ns: %s expected %h got %h",
                               $time, sig, exp, got));
   endtask

   function automatic logic [W-1:0] sext(input logic [10:0] field, input int bits);
      logic [W-1:0] v;
      v = W'(field) << (W - bits); // field sign bit into bit 15
      return $signed(v) >>> (W - bits);
   endfunction

   function automatic logic [W-1:0] reg_word(input logic [3:0] op, input int rd,
                                             input int rs, input logic [2:0] sub,
                                             input int rt);
      return {op, 3'(rd), 3'(rs), sub, 3'(rt)};
   endfunction

   // store reg src to r7 + off
   function automatic logic [W-1:0] str_word(input int src, input int off);
      return {lc4_pkg::OP_STR, 3'(src), 3'd7, 6'(off)};
   endfunction

   // one real instruction then four NOPs
   task automatic put_slot(input logic [W-1:0] insn);
      imem[build_ptr] = insn;
      for (int i = 1; i <= 4; i++) begin
         imem[build_ptr + i] = lc4_pkg::NOP_INSN;
      end
      build_ptr += 5;
   endtask

   task automatic build_program();
      int         kind;
      int         rd;
      int         rs;
      int         rt;
      logic [2:0] sub;
      build_ptr = P_RESET_PC;
      put_slot({lc4_pkg::OP_CONST, 3'd7, 9'($urandom)}); // r7 is the store base
      for (int g = 0; g < N_GROUPS; g++) begin
         kind = $urandom_range(0, 7);
         rd   = $urandom_range(0, 6);
         rs   = $urandom_range(0, 7);
         rt   = $urandom_range(0, 7);
         sub  = ($urandom_range(0, 1) == 0) ? lc4_pkg::ARITH_ADD : lc4_pkg::ARITH_SUB;
         case (kind)
            0: put_slot({lc4_pkg::OP_CONST, 3'(rd),
                         ($urandom_range(0, 3) == 0) ? 9'd0 : 9'($urandom)});
            1: put_slot(reg_word(lc4_pkg::OP_ARITH, rd, rs, sub, rt));
            2: put_slot({lc4_pkg::OP_ARITH, 3'(rd), 3'(rs), 1'b1, 5'($urandom)}); // ADD imm
            3: put_slot(reg_word(lc4_pkg::OP_LOGIC, rd, rs, 3'($urandom_range(0, 3)), rt));
            4: put_slot({lc4_pkg::OP_LOGIC, 3'(rd), 3'(rs), 1'b1, 5'($urandom)}); // AND imm
            5: put_slot({lc4_pkg::OP_LDR, 3'(rd), 3'(rs), 6'($urandom)});
            6: begin
               // offset 9 steps over the delay slots and one store slot
               put_slot({lc4_pkg::OP_BR, 3'($urandom_range(1, 7)), 9'd9});
               put_slot(str_word(rt, $urandom));
            end
            default: begin
               put_slot({lc4_pkg::OP_JMP, 1'b1, 11'd9});
               put_slot(str_word(rt, $urandom)); // never executed
            end
         endcase
         if (kind < 6)
            put_slot(str_word(rd, $urandom)); // push the result out to memory
      end
      put_slot(str_word(0, 0)); // final store ends the run
   endtask

   // ISA model stepping once per fetch cycle with control taking effect five fetches later
   task automatic run_model();
      logic [W-1:0]       regs [lc4_pkg::NUM_REGS];
      lc4_pkg::lc4_insn_u ins;
      logic [W-1:0]       pc, a, b, val, addr, tgt;
      logic [2:0]         nzp;
      logic               wr;
      int                 redir_cnt;
      pc        = P_RESET_PC;
      nzp       = 3'b000;
      redir_cnt = 0;
      tgt       = '0;
      n_st_exp  = 0;
      foreach (regs[i]) regs[i] = '0;
      for (int k = 0; k < MAX_FETCH; k++) begin
         fetch_exp[k] = pc;
         ins  = imem[pc];
         a    = regs[ins.r.rs];
         b    = regs[ins.r.rt];
         addr = a + sext(11'(ins.o.imm9[5:0]), 6);
         val  = '0;
         wr   = 1'b1;
         fetch_mem[k] = (ins.r.opcode == lc4_pkg::OP_LDR) || (ins.r.opcode == lc4_pkg::OP_STR);
         case (ins.r.opcode)
            lc4_pkg::OP_ARITH: begin
               if (ins.r.sub_op[2])
                  val = a + sext(11'(ins.o.imm9[4:0]), 5);
               else if (ins.r.sub_op == lc4_pkg::ARITH_SUB)
                  val = a - b;
               else if (ins.r.sub_op == lc4_pkg::ARITH_ADD)
                  val = a + b;
               else
                  wr = 1'b0; // unknown sub-op acts as a NOP
            end
            lc4_pkg::OP_LOGIC: begin
               if (ins.r.sub_op[2])
                  val = a & sext(11'(ins.o.imm9[4:0]), 5);
               else if (ins.r.sub_op == lc4_pkg::LOGIC_AND)
                  val = a & b;
               else if (ins.r.sub_op == lc4_pkg::LOGIC_NOT)
                  val = ~a;
               else if (ins.r.sub_op == lc4_pkg::LOGIC_OR)
                  val = a | b;
               else
                  val = a ^ b;
            end
            lc4_pkg::OP_CONST: val = sext(11'(ins.o.imm9), 9);
            lc4_pkg::OP_LDR:   val = ref_mem[addr];
            lc4_pkg::OP_STR: begin
               wr = 1'b0;
               ref_mem[addr] = regs[ins.r.rd];
               if (n_st_exp < MAX_ST) begin
                  st_addr_exp[n_st_exp] = addr;
                  st_data_exp[n_st_exp] = regs[ins.r.rd];
                  n_st_exp++;
               end
            end
            lc4_pkg::OP_BR: begin
               wr = 1'b0;
               if (|(ins.o.rd_nzp & nzp)) begin
                  redir_cnt = 5;
                  tgt = pc + 1 + sext(11'(ins.o.imm9), 9);
               end
            end
            lc4_pkg::OP_JMP: begin
               wr = 1'b0;
               if (ins.o.rd_nzp[2]) begin
                  redir_cnt = 5;
                  tgt = pc + 1 + sext({ins.o.rd_nzp[1:0], ins.o.imm9}, 11);
               end
            end
            default: wr = 1'b0;
         endcase
         if (wr) begin
            regs[ins.r.rd] = val;
            nzp = val[W-1] ? 3'b100 : (val == '0) ? 3'b010 : 3'b001;
         end
         pc = (redir_cnt == 1) ? tgt : pc + 1;
         if (redir_cnt > 0)
            redir_cnt--;
      end
   endtask

   // expected values for the next cycle's checks
   always @(posedge gwe) begin
      if (i_rst_n) begin
         cyc        <= cyc + 1;
         exp_mem_op <= (cyc >= 2) ? fetch_mem[cyc - 2] : 1'b0; // fetched 3 cycles back
         if (cyc + 1 < MAX_FETCH)
            exp_pc <= fetch_exp[cyc + 1];
         if (o_dmem_we && st_seen + 1 < MAX_ST) begin
            exp_st_addr <= st_addr_exp[st_seen + 1];
            exp_st_data <= st_data_exp[st_seen + 1];
         end
         if (o_dmem_we)
            st_seen <= st_seen + 1;
      end
   end

   a_reset_idle : assert property (@(posedge gwe)
      !i_rst_n |-> (!o_dmem_we && o_dmem_addr == '0))
      else begin
         if ($sampled(o_dmem_we) !== 1'b0)
            report_mismatch("o_dmem_we in reset", '0, $sampled(o_dmem_we));
         else
            report_mismatch("o_dmem_addr in reset", '0, $sampled(o_dmem_addr));
         $fatal(1, "dmem port active during reset");
      end

   a_reset_pc : assert property (@(posedge gwe) $rose(i_rst_n) |-> o_cur_pc == P_RESET_PC)
      else begin
         report_mismatch("o_cur_pc", P_RESET_PC, $sampled(o_cur_pc));
         $fatal(1, "wrong boot address");
      end

   a_fetch : assert property (@(posedge gwe) disable iff (!i_rst_n) o_cur_pc == exp_pc)
      else begin
         report_mismatch("o_cur_pc", $sampled(exp_pc), $sampled(o_cur_pc));
         $fatal(1, "fetch sequence broken");
      end

   a_st_count : assert property (@(posedge gwe) disable iff (!i_rst_n)
      o_dmem_we |-> st_seen < n_st_exp)
      else begin
         report_failure($sformatf("store at %0d ns that the program never makes", $time));
         $fatal(1, "extra store");
      end

   a_st_addr : assert property (@(posedge gwe) disable iff (!i_rst_n)
      o_dmem_we |-> o_dmem_addr == exp_st_addr)
      else begin
         report_mismatch("o_dmem_addr", $sampled(exp_st_addr), $sampled(o_dmem_addr));
         $fatal(1, "store address wrong");
      end

   a_st_data : assert property (@(posedge gwe) disable iff (!i_rst_n)
      o_dmem_we |-> o_dmem_towrite == exp_st_data)
      else begin
         report_mismatch("o_dmem_towrite", $sampled(exp_st_data), $sampled(o_dmem_towrite));
         $fatal(1, "store data wrong");
      end

   a_mem_idle : assert property (@(posedge gwe) disable iff (!i_rst_n)
      !exp_mem_op |-> (!o_dmem_we && o_dmem_addr == '0))
      else begin
         if ($sampled(o_dmem_we) !== 1'b0)
            report_mismatch("o_dmem_we when idle", '0, $sampled(o_dmem_we));
         else
            report_mismatch("o_dmem_addr when idle", '0, $sampled(o_dmem_addr));
         $fatal(1, "dmem port not idle");
      end

   initial begin
      int wait_cycles;
      i_rst_n <= 1'b0;
      void'($urandom(19681));
      for (int adr = 0; adr < 2**W; adr++) begin
         imem[adr]    = lc4_pkg::NOP_INSN;
         dmem[adr]    = W'($urandom);
         ref_mem[adr] = dmem[adr];
      end
      build_program();
      run_model();
      exp_pc      = fetch_exp[0];
      exp_st_addr = st_addr_exp[0];
      exp_st_data = st_data_exp[0];
      repeat (5) @(posedge gwe);
      i_rst_n <= 1'b1;
      wait_cycles = 0;
      while (st_seen < n_st_exp) begin // last store marks the end
         @(posedge gwe);
         wait_cycles++;
         if (wait_cycles > TIMEOUT) begin
            report_failure($sformatf("timeout after %0d cycles, %0d of %0d stores seen",
                                     wait_cycles, st_seen, n_st_exp));
            $fatal(1, "no final store");
         end
      end
      repeat (8) @(posedge gwe); // let the idle checks run a little longer
      $display("Test completed successfully");
      $finish;
   end

endmodule

/* hw/lc4_core.sv */
/*
 * LC4 five-stage pipeline top level
 * stage modules, register file and the two stage bundles
 */
`timescale 1ns/100ps

module lc4_core #(
   parameter logic [lc4_pkg::WORD_W-1:0] P_RESET_PC = lc4_pkg::RESET_PC
) (
   input  logic                        gwe,
   input  logic                        i_rst_n,
   input  logic [lc4_pkg::WORD_W-1:0]  i_cur_insn,     // imem read data
   input  logic [lc4_pkg::WORD_W-1:0]  i_dmem_data,    // dmem read data
   output logic [lc4_pkg::WORD_W-1:0]  o_cur_pc,       // imem address
   output logic [lc4_pkg::WORD_W-1:0]  o_dmem_addr,
   output logic                        o_dmem_we,
   output logic [lc4_pkg::WORD_W-1:0]  o_dmem_towrite
);

   logic [lc4_pkg::REG_SEL_W-1:0] rs_sel, rt_sel, rd_sel;
   logic [lc4_pkg::WORD_W-1:0]    rs_data, rt_data, wdata, target;
   logic                          rd_we, redirect;

   lc4_stage_if de_if ();  // decode -> execute
   lc4_stage_if mw_if ();  // memory -> writeback

   lc4_fetch_decode #(
      .P_RESET_PC (P_RESET_PC)
   ) u_fetch_decode (
      .gwe        (gwe),
      .i_rst_n    (i_rst_n),
      .i_cur_insn (i_cur_insn),
      .i_redirect (redirect),
      .i_target   (target),
      .i_rs_data  (rs_data),
      .i_rt_data  (rt_data),
      .o_cur_pc   (o_cur_pc),
      .o_rs_sel   (rs_sel),
      .o_rt_sel   (rt_sel),
      .de_if      (de_if.src)
   );

   lc4_regfile u_regfile (
      .gwe       (gwe),
      .i_rst_n   (i_rst_n),
      .i_rs_sel  (rs_sel),
      .i_rt_sel  (rt_sel),
      .i_rd_sel  (rd_sel),
      .i_wdata   (wdata),
      .i_rd_we   (rd_we),
      .o_rs_data (rs_data),
      .o_rt_data (rt_data)
   );

   lc4_exec_mem u_exec_mem (
      .gwe            (gwe),
      .i_rst_n        (i_rst_n),
      .i_dmem_data    (i_dmem_data),
      .de_if          (de_if.dst),
      .mw_if          (mw_if.src),
      .o_dmem_addr    (o_dmem_addr),
      .o_dmem_we      (o_dmem_we),
      .o_dmem_towrite (o_dmem_towrite)
   );

   lc4_writeback u_writeback (
      .gwe        (gwe),
      .i_rst_n    (i_rst_n),
      .mw_if      (mw_if.dst),
      .o_rd_we    (rd_we),
      .o_rd_sel   (rd_sel),
      .o_wdata    (wdata),
      .o_redirect (redirect),
      .o_target   (target)
   );

endmodule

/* hw/lc4_writeback.sv */
/*
 * writeback stage
 * M/W latch, result select, NZP register, branch resolution and redirect
 */
`timescale 1ns/100ps

module lc4_writeback (
   input  logic                           gwe,
   input  logic                           i_rst_n,
   lc4_stage_if.dst                       mw_if,
   output logic                           o_rd_we,
   output logic [lc4_pkg::REG_SEL_W-1:0]  o_rd_sel,
   output logic [lc4_pkg::WORD_W-1:0]     o_wdata,
   output logic                           o_redirect,
   output logic [lc4_pkg::WORD_W-1:0]     o_target
);

   lc4_pkg::lc4_insn_u         w_insn;
   logic                       w_regfile_we, w_nzp_we, w_is_load, w_is_branch, w_is_jump;
   logic [lc4_pkg::WORD_W-1:0] w_result, w_mem_data;
   logic [2:0]                 nzp_q, nzp_next;
   logic                       br_taken;

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         w_insn       <= lc4_pkg::NOP_INSN;
         w_regfile_we <= 1'b0;
         w_nzp_we     <= 1'b0;
         w_is_load    <= 1'b0;
         w_is_branch  <= 1'b0;
         w_is_jump    <= 1'b0;
      end else begin
         w_insn       <= mw_if.insn;
         w_regfile_we <= mw_if.regfile_we;
         w_nzp_we     <= mw_if.nzp_we;
         w_is_load    <= mw_if.is_load;
         w_is_branch  <= mw_if.is_branch;
         w_is_jump    <= mw_if.is_jump;
      end
   end

   always_ff @(posedge gwe) begin
      w_result   <= mw_if.result;
      w_mem_data <= mw_if.mem_data; // load data from the memory cycle
   end

   assign o_wdata  = w_is_load ? w_mem_data : w_result;
   assign o_rd_we  = w_regfile_we;
   assign o_rd_sel = w_insn.r.rd;

   // sign of the value going to the regfile
   assign nzp_next = o_wdata[lc4_pkg::WORD_W-1] ? 3'b100 :
                     (o_wdata == '0)            ? 3'b010 : 3'b001;

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n)
         nzp_q <= 3'b000; // nothing taken until the first write
      else if (w_nzp_we)
         nzp_q <= nzp_next;
   end

   assign br_taken   = w_is_branch && |(w_insn.o.rd_nzp & nzp_q);
   assign o_redirect = br_taken || w_is_jump;
   assign o_target   = w_result; // ALU formed pc+1+offset

   a_nzp_onehot : assert property (@(posedge gwe) disable iff (!i_rst_n)
      $onehot0(nzp_q));

endmodule

/* hw/lc4_exec_mem.sv */
/*
 * execute and memory stages
 * D/X and X/M latches, ALU, data memory port, memory bundle output
 */
`timescale 1ns/100ps

module lc4_exec_mem (
   input  logic                        gwe,
   input  logic                        i_rst_n,
   input  logic [lc4_pkg::WORD_W-1:0]  i_dmem_data,
   lc4_stage_if.dst                    de_if,
   lc4_stage_if.src                    mw_if,
   output logic [lc4_pkg::WORD_W-1:0]  o_dmem_addr,
   output logic                        o_dmem_we,
   output logic [lc4_pkg::WORD_W-1:0]  o_dmem_towrite
);

   lc4_pkg::lc4_insn_u         x_insn, m_insn;
   logic [lc4_pkg::WORD_W-1:0] x_pc, x_rs_data, x_rt_data, x_result;
   logic [lc4_pkg::WORD_W-1:0] m_pc, m_rt_data, m_result;
   logic [5:0]                 x_flags, m_flags; // {regfile_we, nzp_we, ld, st, br, jmp}

   // control state cleared to a NOP on reset
   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         x_insn  <= lc4_pkg::NOP_INSN;
         x_flags <= '0;
         m_insn  <= lc4_pkg::NOP_INSN;
         m_flags <= '0;
      end else begin
         x_insn  <= de_if.insn;
         x_flags <= {de_if.regfile_we, de_if.nzp_we, de_if.is_load,
                     de_if.is_store, de_if.is_branch, de_if.is_jump};
         m_insn  <= x_insn;
         m_flags <= x_flags;
      end
   end

   // payload
   always_ff @(posedge gwe) begin
      x_pc      <= de_if.pc;
      x_rs_data <= de_if.rs_data;
      x_rt_data <= de_if.rt_data;
      m_pc      <= x_pc;
      m_rt_data <= x_rt_data; // store data
      m_result  <= x_result;
   end

   lc4_alu u_alu (
      .i_insn    (x_insn),
      .i_pc      (x_pc),
      .i_rs_data (x_rs_data),
      .i_rt_data (x_rt_data),
      .o_result  (x_result)
   );

   // data memory port drives an address only for loads and stores
   assign o_dmem_addr    = (m_flags[3] || m_flags[2]) ? m_result : '0;
   assign o_dmem_we      = m_flags[2];
   assign o_dmem_towrite = m_rt_data;

   assign mw_if.pc         = m_pc;
   assign mw_if.insn       = m_insn;
   assign mw_if.rs_data    = '0; // base reg only matters in execute
   assign mw_if.rt_data    = m_rt_data;
   assign {mw_if.regfile_we, mw_if.nzp_we, mw_if.is_load,
           mw_if.is_store, mw_if.is_branch, mw_if.is_jump} = m_flags;
   assign mw_if.result     = m_result;
   assign mw_if.mem_data   = i_dmem_data; // captured by writeback at the edge

   // load and store flags in memory belong to the opcode latched beside them
   a_ld_st_excl : assert property (@(posedge gwe) disable iff (!i_rst_n)
      (!m_flags[3] || m_insn.r.opcode == lc4_pkg::OP_LDR) &&
      (!m_flags[2] || m_insn.r.opcode == lc4_pkg::OP_STR));

endmodule

/* hw/lc4_fetch_decode.sv */
/*
 * fetch and decode stages
 * fetch PC with redirect, F/D latch, decoder, decode bundle output
 */
`timescale 1ns/100ps

module lc4_fetch_decode #(
   parameter logic [lc4_pkg::WORD_W-1:0] P_RESET_PC = lc4_pkg::RESET_PC
) (
   input  logic                           gwe,
   input  logic                           i_rst_n,
   input  logic [lc4_pkg::WORD_W-1:0]     i_cur_insn,   // from instruction memory
   input  logic                           i_redirect,   // taken branch or jump in writeback
   input  logic [lc4_pkg::WORD_W-1:0]     i_target,
   input  logic [lc4_pkg::WORD_W-1:0]     i_rs_data,
   input  logic [lc4_pkg::WORD_W-1:0]     i_rt_data,
   output logic [lc4_pkg::WORD_W-1:0]     o_cur_pc,
   output logic [lc4_pkg::REG_SEL_W-1:0]  o_rs_sel,
   output logic [lc4_pkg::REG_SEL_W-1:0]  o_rt_sel,
   lc4_stage_if.src                       de_if
);

   logic [lc4_pkg::WORD_W-1:0] f_pc;
   logic [lc4_pkg::WORD_W-1:0] d_pc;
   lc4_pkg::lc4_insn_u         d_insn;

   // fetch pc steps by one unless writeback redirects
   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         f_pc   <= P_RESET_PC;
         d_insn <= lc4_pkg::NOP_INSN;
      end else begin
         f_pc   <= i_redirect ? i_target : f_pc + 1'b1;
         d_insn <= i_cur_insn;
      end
   end

   always_ff @(posedge gwe) begin
      d_pc <= f_pc; // pc of the word in decode
   end

   assign o_cur_pc = f_pc;

   lc4_decoder u_decoder (
      .i_insn       (d_insn),
      .o_rs_sel     (o_rs_sel),
      .o_rt_sel     (o_rt_sel),
      .o_regfile_we (de_if.regfile_we),
      .o_nzp_we     (de_if.nzp_we),
      .o_is_load    (de_if.is_load),
      .o_is_store   (de_if.is_store),
      .o_is_branch  (de_if.is_branch),
      .o_is_jump    (de_if.is_jump)
   );

   assign de_if.pc       = d_pc;
   assign de_if.insn     = d_insn;
   assign de_if.rs_data  = i_rs_data; // regfile read of this cycle
   assign de_if.rt_data  = i_rt_data;
   assign de_if.result   = '0;        // nothing computed yet in decode
   assign de_if.mem_data = '0;

   // fetch address must be clean once out of reset, it drives the imem
   a_pc_known : assert property (@(posedge gwe) disable iff (!i_rst_n)
      !$isunknown(o_cur_pc));

endmodule

/* hw/lc4_alu.sv */
/*
 * LC4 ALU
 * arithmetic, logic, CONST, load/store address and branch/jump targets
 */
`timescale 1ns/100ps

module lc4_alu (
   input  lc4_pkg::lc4_insn_u          i_insn,
   input  logic [lc4_pkg::WORD_W-1:0]  i_pc,
   input  logic [lc4_pkg::WORD_W-1:0]  i_rs_data,
   input  logic [lc4_pkg::WORD_W-1:0]  i_rt_data,
   output logic [lc4_pkg::WORD_W-1:0]  o_result
);

   localparam int W = lc4_pkg::WORD_W;

   logic [W-1:0] imm5_sx;  // ADD imm / AND imm
   logic [W-1:0] imm6_sx;  // LDR / STR offset
   logic [W-1:0] imm9_sx;  // BR offset, CONST value
   logic [W-1:0] imm11_sx; // JMP offset
   logic [W-1:0] pc_inc;

   assign imm5_sx  = {{(W-5){i_insn.o.imm9[4]}}, i_insn.o.imm9[4:0]};
   assign imm6_sx  = {{(W-6){i_insn.o.imm9[5]}}, i_insn.o.imm9[5:0]};
   assign imm9_sx  = {{(W-9){i_insn.o.imm9[8]}}, i_insn.o.imm9};
   assign imm11_sx = {{(W-11){i_insn.o.rd_nzp[1]}}, i_insn.o.rd_nzp[1:0], i_insn.o.imm9};
   assign pc_inc   = i_pc + 1'b1;

   always_comb begin
      o_result = '0;
      case (i_insn.r.opcode)
         lc4_pkg::OP_BR:    o_result = pc_inc + imm9_sx;  // taken target
         lc4_pkg::OP_ARITH: begin
            if (i_insn.r.sub_op[2])
               o_result = i_rs_data + imm5_sx;
            else if (i_insn.r.sub_op == lc4_pkg::ARITH_SUB)
               o_result = i_rs_data - i_rt_data;
            else
               o_result = i_rs_data + i_rt_data; // ADD, other sub-ops are not written
         end
         lc4_pkg::OP_LOGIC: begin
            if (i_insn.r.sub_op[2]) begin
               o_result = i_rs_data & imm5_sx;
            end else begin
               case (i_insn.r.sub_op)
                  lc4_pkg::LOGIC_AND: o_result = i_rs_data & i_rt_data;
                  lc4_pkg::LOGIC_NOT: o_result = ~i_rs_data;
                  lc4_pkg::LOGIC_OR:  o_result = i_rs_data | i_rt_data;
                  default:            o_result = i_rs_data ^ i_rt_data; // XOR
               endcase
            end
         end
         lc4_pkg::OP_LDR,
         lc4_pkg::OP_STR:   o_result = i_rs_data + imm6_sx; // effective address
         lc4_pkg::OP_CONST: o_result = imm9_sx;
         lc4_pkg::OP_JMP:   o_result = pc_inc + imm11_sx;
         default: ;
      endcase
   end

endmodule

/* hw/lc4_regfile.sv */
/*
 * LC4 register file, eight by sixteen
 * two combinational read ports, one write port at the clock edge
 */
`timescale 1ns/100ps

module lc4_regfile (
   input  logic                           gwe,
   input  logic                           i_rst_n,
   input  logic [lc4_pkg::REG_SEL_W-1:0]  i_rs_sel,
   input  logic [lc4_pkg::REG_SEL_W-1:0]  i_rt_sel,
   input  logic [lc4_pkg::REG_SEL_W-1:0]  i_rd_sel,
   input  logic [lc4_pkg::WORD_W-1:0]     i_wdata,
   input  logic                           i_rd_we,
   output logic [lc4_pkg::WORD_W-1:0]     o_rs_data,
   output logic [lc4_pkg::WORD_W-1:0]     o_rt_data
);

   logic [lc4_pkg::WORD_W-1:0] regs [lc4_pkg::NUM_REGS];

   // no bypass: a write shows up on the read ports the cycle after
   assign o_rs_data = regs[i_rs_sel];
   assign o_rt_data = regs[i_rt_sel];

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 0; i < lc4_pkg::NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_rd_we) begin
         regs[i_rd_sel] <= i_wdata;
      end
   end

endmodule

/* hw/lc4_decoder.sv */
/*
 * LC4 instruction decoder
 * register selects and control flags for the kept subset
 */
`timescale 1ns/100ps

module lc4_decoder (
   input  lc4_pkg::lc4_insn_u             i_insn,
   output logic [lc4_pkg::REG_SEL_W-1:0]  o_rs_sel,
   output logic [lc4_pkg::REG_SEL_W-1:0]  o_rt_sel,
   output logic                           o_regfile_we,
   output logic                           o_nzp_we,
   output logic                           o_is_load,
   output logic                           o_is_store,
   output logic                           o_is_branch,
   output logic                           o_is_jump
);

   logic is_str; // STR takes its data reg from insn[11:9]

   assign is_str   = (i_insn.r.opcode == lc4_pkg::OP_STR);
   assign o_rs_sel = i_insn.r.rs;                          // always insn[8:6]
   assign o_rt_sel = is_str ? i_insn.r.rd : i_insn.r.rt;

   always_comb begin
      // unknown opcodes fall through as NOPs
      o_regfile_we = 1'b0;
      o_nzp_we     = 1'b0;
      o_is_load    = 1'b0;
      o_is_store   = 1'b0;
      o_is_branch  = 1'b0;
      o_is_jump    = 1'b0;
      case (i_insn.r.opcode)
         lc4_pkg::OP_BR: begin
            o_is_branch = |i_insn.o.rd_nzp; // empty mask is the NOP
         end
         lc4_pkg::OP_ARITH: begin
            // only ADD, SUB and ADD imm are kept
            if (i_insn.r.sub_op[2] || i_insn.r.sub_op == lc4_pkg::ARITH_ADD ||
                i_insn.r.sub_op == lc4_pkg::ARITH_SUB) begin
               o_regfile_we = 1'b1;
               o_nzp_we     = 1'b1;
            end
         end
         lc4_pkg::OP_LOGIC: begin
            o_regfile_we = 1'b1; // every logic sub-op is kept
            o_nzp_we     = 1'b1;
         end
         lc4_pkg::OP_LDR: begin
            o_regfile_we = 1'b1;
            o_nzp_we     = 1'b1;
            o_is_load    = 1'b1;
         end
         lc4_pkg::OP_STR:   o_is_store = 1'b1;
         lc4_pkg::OP_CONST: begin
            o_regfile_we = 1'b1;
            o_nzp_we     = 1'b1;
         end
         lc4_pkg::OP_JMP:   o_is_jump = i_insn.o.rd_nzp[2]; // JMPR form dropped
         default: ;
      endcase
   end

endmodule

/* hw/lc4_stage_if.sv */
/*
 * pipeline stage bundle: one instruction with its pc, operands,
 * control flags, ALU result and load data
 */
`timescale 1ns/100ps

interface lc4_stage_if;

   logic [lc4_pkg::WORD_W-1:0] pc;
   lc4_pkg::lc4_insn_u         insn;
   logic [lc4_pkg::WORD_W-1:0] rs_data;
   logic [lc4_pkg::WORD_W-1:0] rt_data;
   logic                       regfile_we; // writes rd
   logic                       nzp_we;     // sets NZP from the result
   logic                       is_load;
   logic                       is_store;
   logic                       is_branch;  // BR with nonempty mask
   logic                       is_jump;    // JMP imm11
   logic [lc4_pkg::WORD_W-1:0] result;     // ALU output
   logic [lc4_pkg::WORD_W-1:0] mem_data;   // data memory read value

   modport src (output pc, insn, rs_data, rt_data, regfile_we, nzp_we, is_load,
                is_store, is_branch, is_jump, result, mem_data);

   modport dst (input pc, insn, rs_data, rt_data, regfile_we, nzp_we, is_load,
                is_store, is_branch, is_jump, result, mem_data);

endinterface

/* hw/lc4_pkg.sv */
/*
 * LC4 shared definitions: data and select widths, boot address, NOP word,
 * opcode and sub-op encodings, and the instruction word union
 */
package lc4_pkg;

   localparam int WORD_W    = 16; // data and address width
   localparam int REG_SEL_W = 3;  // register select width
   localparam int NUM_REGS  = 8;

   localparam logic [WORD_W-1:0] RESET_PC = 16'h8200; // boot address
   localparam logic [WORD_W-1:0] NOP_INSN = 16'h0000; // BR with empty nzp mask

   // major opcodes, insn[15:12]
   localparam logic [3:0] OP_BR    = 4'b0000;
   localparam logic [3:0] OP_ARITH = 4'b0001;
   localparam logic [3:0] OP_LOGIC = 4'b0101;
   localparam logic [3:0] OP_LDR   = 4'b0110;
   localparam logic [3:0] OP_STR   = 4'b0111;
   localparam logic [3:0] OP_CONST = 4'b1001;
   localparam logic [3:0] OP_JMP   = 4'b1100; // offset form when insn[11] is set

   // arithmetic sub-ops, insn[5:3]
   // sub_op[2] set selects the immediate form (ADD imm5)
   localparam logic [2:0] ARITH_ADD = 3'b000;
   localparam logic [2:0] ARITH_SUB = 3'b010;

   // logic sub-ops, insn[5:3]
   // sub_op[2] set selects AND imm5
   localparam logic [2:0] LOGIC_AND = 3'b000;
   localparam logic [2:0] LOGIC_NOT = 3'b001;
   localparam logic [2:0] LOGIC_OR  = 3'b010;
   localparam logic [2:0] LOGIC_XOR = 3'b011;

   // one instruction word, seen either as a register form or an offset form
   typedef union packed {
      struct packed {
         logic [3:0]           opcode;
         logic [REG_SEL_W-1:0] rd;     // dest, or store data reg for STR
         logic [REG_SEL_W-1:0] rs;     // base / first source
         logic [2:0]           sub_op;
         logic [REG_SEL_W-1:0] rt;     // second source
      } r;
      struct packed {
         logic [3:0]           opcode;
         logic [2:0]           rd_nzp; // rd, or nzp mask for BR
         logic [8:0]           imm9;   // imm5 and imm6 sit in the low bits
      } o;
   } lc4_insn_u;

endpackage
